// ==== build.f ====
+incdir+design
+incdir+verif
design/decode_pkg.sv
design/instr_decoder.sv
design/imm_gen.sv
design/issue_control.sv
design/issue_reg.sv
design/decode_stage.sv
verif/tb_decode_stage.sv

// ==== design/decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define ALU_OP_W    12

// one-hot alu operation, bit positions
`define ALU_ADD   0
`define ALU_SUB   1
`define ALU_SLT   2
`define ALU_SLTU  3
`define ALU_AND   4
`define ALU_NOR   5
`define ALU_OR    6
`define ALU_XOR   7
`define ALU_SLL   8
`define ALU_SRL   9
`define ALU_SRA   10
`define ALU_LUI   11

// major opcode, instr[31:26]
`define OP6_ARITH   6'h00
`define OP6_LU12I   6'h05
`define OP6_PCADDU  6'h07
`define OP6_MEM     6'h0a
`define OP6_JIRL    6'h13
`define OP6_B       6'h14
`define OP6_BL      6'h15
`define OP6_BEQ     6'h16
`define OP6_BNE     6'h17
`define OP6_BLT     6'h18
`define OP6_BGE     6'h19
`define OP6_BLTU    6'h1a
`define OP6_BGEU    6'h1b

// arith group, instr[25:22]
`define OP4_3R      4'h0
`define OP4_SHIFTI  4'h1
`define OP4_SLTI    4'h8
`define OP4_SLTUI   4'h9
`define OP4_ADDI    4'ha
`define OP4_ANDI    4'hd
`define OP4_ORI     4'he
`define OP4_XORI    4'hf

// instr[21:20]
`define OP2_SHIFTI  2'h0
`define OP2_3R      2'h1

// 3r and shift-imm function, instr[19:15]
`define OP5_ADD   5'h00
`define OP5_SLLI  5'h01
`define OP5_SUB   5'h02
`define OP5_SLT   5'h04
`define OP5_SLTU  5'h05
`define OP5_NOR   5'h08
`define OP5_AND   5'h09
`define OP5_SRLI  5'h09
`define OP5_OR    5'h0a
`define OP5_XOR   5'h0b
`define OP5_SLL   5'h0e
`define OP5_SRL   5'h0f
`define OP5_SRA   5'h10
`define OP5_SRAI  5'h11

// memory group, instr[25:22]
`define OP4_LD_B   4'h0
`define OP4_LD_H   4'h1
`define OP4_LD_W   4'h2
`define OP4_ST_B   4'h4
`define OP4_ST_H   4'h5
`define OP4_ST_W   4'h6
`define OP4_LD_BU  4'h8
`define OP4_LD_HU  4'h9

`define MASK_B  4'h1
`define MASK_H  4'h3
`define MASK_W  4'hf

`endif

// ==== design/decode_pkg.sv ====
`include "decode_defs.svh"

package decode_pkg;

  // one instruction word, read in whichever format the opcode implies
  typedef union packed {
    struct packed {
      logic [5:0]             op6;
      logic [3:0]             op4;
      logic [1:0]             op2;
      logic [4:0]             op5;
      logic [`REG_ADDR_W-1:0] rk;
      logic [`REG_ADDR_W-1:0] rj;
      logic [`REG_ADDR_W-1:0] rd;
    } fmt_3r;
    struct packed {
      logic [9:0]             op10;
      logic [11:0]            imm12;
      logic [`REG_ADDR_W-1:0] rj;
      logic [`REG_ADDR_W-1:0] rd;
    } fmt_2ri12;
    struct packed {
      logic [6:0]             op7;
      logic [19:0]            imm20;
      logic [`REG_ADDR_W-1:0] rd;
    } fmt_1ri20;
    struct packed {
      logic [5:0]             op6;
      logic [15:0]            imm16;
      logic [`REG_ADDR_W-1:0] rj;
      logic [`REG_ADDR_W-1:0] rd;
    } fmt_2ri16;
    struct packed {
      logic [5:0]  op6;
      logic [15:0] offs_lo;
      logic [9:0]  offs_hi;
    } fmt_i26;
  } instr_u;

  typedef struct packed {
    logic               valid;
    logic [`DATA_W-1:0] pc;
    instr_u             instr;
  } fetch_slot_t;

  typedef struct packed {
    logic [`ALU_OP_W-1:0]   alu_op;
    logic [3:0]             mem_mask;
    logic                   load;
    logic                   store;
    logic                   is_unsigned;
    logic                   may_jump;
    logic                   use_rj_value;
    logic                   use_less;
    logic                   need_less;
    logic                   use_zero;
    logic                   need_zero;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic                   src2_is_4;
    logic                   gr_we;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`DATA_W-1:0]     imm;
    logic [`REG_ADDR_W-1:0] rj_addr;
    logic [`REG_ADDR_W-1:0] rkd_addr;
    logic [`DATA_W-1:0]     rj_value;
    logic [`DATA_W-1:0]     rkd_value;
    logic [`DATA_W-1:0]     pc;
  } decoded_op_t;

  typedef struct packed {
    logic        valid;
    decoded_op_t op;
  } issue_slot_t;

  // read addresses ride along so the pairing check needs nothing else
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] dest;
    logic                   gr_we;
    logic                   use_rj;
    logic                   use_rkd;
    logic                   may_jump;
    logic                   mem_access;
    logic [`REG_ADDR_W-1:0] rj_addr;
    logic [`REG_ADDR_W-1:0] rkd_addr;
  } hazard_info_t;

  typedef enum logic [2:0] {
    IMM_UI5,
    IMM_SI12,
    IMM_UI12,
    IMM_SI16,
    IMM_SI20,
    IMM_SI26,
    IMM_NONE
  } imm_kind_t;

endpackage

// ==== design/decode_stage.sv ====
`include "decode_defs.svh"

module decode_stage import decode_pkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             ready,
  input  logic                             flush,
  input  fetch_slot_t                      slot0,
  input  fetch_slot_t                      slot1,
  input  logic [3:0][`DATA_W-1:0]          rf_data,
  output logic [1:0]                       pop,
  output logic [3:0][`REG_ADDR_W-1:0]      rf_addr,
  output issue_slot_t                      issue0,
  output issue_slot_t                      issue1
);

  imm_kind_t          imm_kind0;
  imm_kind_t          imm_kind1;
  logic [`DATA_W-1:0] imm0;
  logic [`DATA_W-1:0] imm1;
  decoded_op_t        op0;
  decoded_op_t        op1;
  hazard_info_t       hazard0;
  hazard_info_t       hazard1;
  logic [1:0]         issue_valid;

  // slot 0 reads ports 0 and 1, slot 1 reads ports 2 and 3
  instr_decoder dec0 (
    .instr     (slot0.instr),
    .pc        (slot0.pc),
    .rj_value  (rf_data[0]),
    .rkd_value (rf_data[1]),
    .imm       (imm0),
    .imm_kind  (imm_kind0),
    .rj_addr   (rf_addr[0]),
    .rkd_addr  (rf_addr[1]),
    .op        (op0),
    .hazard    (hazard0)
  );

  instr_decoder dec1 (
    .instr     (slot1.instr),
    .pc        (slot1.pc),
    .rj_value  (rf_data[2]),
    .rkd_value (rf_data[3]),
    .imm       (imm1),
    .imm_kind  (imm_kind1),
    .rj_addr   (rf_addr[2]),
    .rkd_addr  (rf_addr[3]),
    .op        (op1),
    .hazard    (hazard1)
  );

  imm_gen imm_gen0 (
    .instr    (slot0.instr),
    .imm_kind (imm_kind0),
    .imm      (imm0)
  );

  imm_gen imm_gen1 (
    .instr    (slot1.instr),
    .imm_kind (imm_kind1),
    .imm      (imm1)
  );

  issue_control issue_ctl (
    .slot0_valid (slot0.valid),
    .slot1_valid (slot1.valid),
    .hazard0     (hazard0),
    .hazard1     (hazard1),
    .ready       (ready),
    .issue_valid (issue_valid),
    .pop         (pop)
  );

  issue_reg out_reg (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .ready       (ready),
    .issue_valid (issue_valid),
    .op0         (op0),
    .op1         (op1),
    .issue0      (issue0),
    .issue1      (issue1)
  );

endmodule

// ==== design/imm_gen.sv ====
`include "decode_defs.svh"

module imm_gen import decode_pkg::*; (
  input  instr_u             instr,
  input  imm_kind_t          imm_kind,
  output logic [`DATA_W-1:0] imm
);

  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;
  logic [4:0]  ui5;

  assign i12 = instr.fmt_2ri12.imm12;
  assign i16 = instr.fmt_2ri16.imm16;
  assign i20 = instr.fmt_1ri20.imm20;
  assign i26 = {instr.fmt_i26.offs_hi, instr.fmt_i26.offs_lo};
  assign ui5 = instr.fmt_3r.rk;

  // branch offsets stay unshifted, execute scales them
  always_comb begin
    case (imm_kind)
      IMM_SI20: imm = {i20, 12'b0};
      IMM_UI5:  imm = {27'b0, ui5};
      IMM_SI26: imm = {{6{i26[25]}}, i26};
      IMM_SI16: imm = {{16{i16[15]}}, i16};
      IMM_SI12: imm = {{20{i12[11]}}, i12};
      default:  imm = {20'b0, i12};
    endcase
  end

endmodule

// ==== design/instr_decoder.sv ====
`include "decode_defs.svh"

module instr_decoder import decode_pkg::*; (
  input  instr_u                 instr,
  input  logic [`DATA_W-1:0]     pc,
  input  logic [`DATA_W-1:0]     rj_value,
  input  logic [`DATA_W-1:0]     rkd_value,
  input  logic [`DATA_W-1:0]     imm,
  output imm_kind_t              imm_kind,
  output logic [`REG_ADDR_W-1:0] rj_addr,
  output logic [`REG_ADDR_W-1:0] rkd_addr,
  output decoded_op_t            op,
  output hazard_info_t           hazard
);

  logic [5:0]             op6;
  logic [9:0]             op10;
  logic [4:0]             op5;
  logic                   is_3r;
  logic                   is_shift_imm;
  logic                   inst_add, inst_sub, inst_slt, inst_sltu;
  logic                   inst_and, inst_or, inst_xor, inst_nor;
  logic                   inst_sll, inst_srl, inst_sra;
  logic                   inst_slli, inst_srli, inst_srai;
  logic                   inst_addi, inst_slti, inst_sltui;
  logic                   inst_andi, inst_ori, inst_xori;
  logic                   inst_lu12i, inst_pcaddu;
  logic                   inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
  logic                   inst_st_b, inst_st_h, inst_st_w;
  logic                   inst_jirl, inst_b, inst_bl;
  logic                   inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  logic                   is_load;
  logic                   is_store;
  logic                   is_cond_branch;
  logic                   may_jump;
  logic                   recognized;
  logic                   src1_is_pc;
  logic                   src2_is_imm;
  logic                   src2_is_4;
  logic                   gr_we;
  logic [`REG_ADDR_W-1:0] dest;
  logic [`ALU_OP_W-1:0]   alu_op;
  logic [3:0]             mem_mask;

  assign op6  = instr.fmt_2ri16.op6;
  assign op10 = instr.fmt_2ri12.op10;
  assign op5  = instr.fmt_3r.op5;

  assign is_3r = (op10 == {`OP6_ARITH, `OP4_3R}) && (instr.fmt_3r.op2 == `OP2_3R);
  assign is_shift_imm = (op10 == {`OP6_ARITH, `OP4_SHIFTI}) &&
                        (instr.fmt_3r.op2 == `OP2_SHIFTI);

  assign inst_add  = is_3r && op5 == `OP5_ADD;
  assign inst_sub  = is_3r && op5 == `OP5_SUB;
  assign inst_slt  = is_3r && op5 == `OP5_SLT;
  assign inst_sltu = is_3r && op5 == `OP5_SLTU;
  assign inst_nor  = is_3r && op5 == `OP5_NOR;
  assign inst_and  = is_3r && op5 == `OP5_AND;
  assign inst_or   = is_3r && op5 == `OP5_OR;
  assign inst_xor  = is_3r && op5 == `OP5_XOR;
  assign inst_sll  = is_3r && op5 == `OP5_SLL;
  assign inst_srl  = is_3r && op5 == `OP5_SRL;
  assign inst_sra  = is_3r && op5 == `OP5_SRA;
  assign inst_slli = is_shift_imm && op5 == `OP5_SLLI;
  assign inst_srli = is_shift_imm && op5 == `OP5_SRLI;
  assign inst_srai = is_shift_imm && op5 == `OP5_SRAI;

  assign inst_addi  = op10 == {`OP6_ARITH, `OP4_ADDI};
  assign inst_slti  = op10 == {`OP6_ARITH, `OP4_SLTI};
  assign inst_sltui = op10 == {`OP6_ARITH, `OP4_SLTUI};
  assign inst_andi  = op10 == {`OP6_ARITH, `OP4_ANDI};
  assign inst_ori   = op10 == {`OP6_ARITH, `OP4_ORI};
  assign inst_xori  = op10 == {`OP6_ARITH, `OP4_XORI};
  assign inst_ld_b  = op10 == {`OP6_MEM, `OP4_LD_B};
  assign inst_ld_h  = op10 == {`OP6_MEM, `OP4_LD_H};
  assign inst_ld_w  = op10 == {`OP6_MEM, `OP4_LD_W};
  assign inst_ld_bu = op10 == {`OP6_MEM, `OP4_LD_BU};
  assign inst_ld_hu = op10 == {`OP6_MEM, `OP4_LD_HU};
  assign inst_st_b  = op10 == {`OP6_MEM, `OP4_ST_B};
  assign inst_st_h  = op10 == {`OP6_MEM, `OP4_ST_H};
  assign inst_st_w  = op10 == {`OP6_MEM, `OP4_ST_W};

  // bit 25 must be clear for the 20-bit immediate forms
  assign inst_lu12i  = instr.fmt_1ri20.op7 == {`OP6_LU12I, 1'b0};
  assign inst_pcaddu = instr.fmt_1ri20.op7 == {`OP6_PCADDU, 1'b0};

  assign inst_jirl = op6 == `OP6_JIRL;
  assign inst_b    = op6 == `OP6_B;
  assign inst_bl   = op6 == `OP6_BL;
  assign inst_beq  = op6 == `OP6_BEQ;
  assign inst_bne  = op6 == `OP6_BNE;
  assign inst_blt  = op6 == `OP6_BLT;
  assign inst_bge  = op6 == `OP6_BGE;
  assign inst_bltu = op6 == `OP6_BLTU;
  assign inst_bgeu = op6 == `OP6_BGEU;

  assign is_load  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
  assign is_store = inst_st_b | inst_st_h | inst_st_w;
  assign is_cond_branch = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign may_jump = is_cond_branch | inst_jirl | inst_b | inst_bl;

  assign recognized = is_3r & (|alu_op) | inst_slli | inst_srli | inst_srai |
                      inst_addi | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori |
                      inst_lu12i | inst_pcaddu | is_load | is_store | may_jump;

  assign alu_op[`ALU_ADD]  = inst_add | inst_addi | is_load | is_store |
                             inst_jirl | inst_bl | inst_pcaddu;
  assign alu_op[`ALU_SUB]  = inst_sub | inst_beq | inst_bne;
  assign alu_op[`ALU_SLT]  = inst_slt | inst_slti | inst_blt | inst_bge;
  assign alu_op[`ALU_SLTU] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
  assign alu_op[`ALU_AND]  = inst_and | inst_andi;
  assign alu_op[`ALU_NOR]  = inst_nor;
  assign alu_op[`ALU_OR]   = inst_or | inst_ori;
  assign alu_op[`ALU_XOR]  = inst_xor | inst_xori;
  assign alu_op[`ALU_SLL]  = inst_sll | inst_slli;
  assign alu_op[`ALU_SRL]  = inst_srl | inst_srli;
  assign alu_op[`ALU_SRA]  = inst_sra | inst_srai;
  assign alu_op[`ALU_LUI]  = inst_lu12i;

  always_comb begin
    if (inst_ld_w | inst_st_w) begin
      mem_mask = `MASK_W;
    end else if (inst_ld_h | inst_ld_hu | inst_st_h) begin
      mem_mask = `MASK_H;
    end else if (inst_ld_b | inst_ld_bu | inst_st_b) begin
      mem_mask = `MASK_B;
    end else begin
      mem_mask = 4'h0;
    end
  end

  always_comb begin
    if (inst_lu12i | inst_pcaddu) begin
      imm_kind = IMM_SI20;
    end else if (inst_slli | inst_srli | inst_srai) begin
      imm_kind = IMM_UI5;
    end else if (inst_b | inst_bl) begin
      imm_kind = IMM_SI26;
    end else if (inst_jirl | is_cond_branch) begin
      imm_kind = IMM_SI16;
    end else if (inst_andi | inst_ori | inst_xori) begin
      imm_kind = IMM_UI12;
    end else if (inst_addi | inst_slti | inst_sltui | is_load | is_store) begin
      imm_kind = IMM_SI12;
    end else begin
      imm_kind = IMM_NONE;
    end
  end

  assign src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu;
  assign src2_is_4   = inst_jirl | inst_bl;
  assign src2_is_imm = inst_slli | inst_srli | inst_srai | inst_addi | inst_slti |
                       inst_sltui | inst_andi | inst_ori | inst_xori | inst_lu12i |
                       inst_pcaddu | is_load | is_store;

  assign gr_we = recognized & ~is_store & ~inst_b & ~is_cond_branch;
  // bl links into r1
  assign dest = inst_bl ? `REG_ADDR_W'd1 : instr.fmt_3r.rd;

  assign rj_addr  = instr.fmt_3r.rj;
  assign rkd_addr = (is_cond_branch | is_store) ? instr.fmt_3r.rd : instr.fmt_3r.rk;

  always_comb begin
    op.alu_op       = alu_op;
    op.mem_mask     = mem_mask;
    op.load         = is_load;
    op.store        = is_store;
    op.is_unsigned  = inst_ld_bu | inst_ld_hu;
    op.may_jump     = may_jump;
    op.use_rj_value = inst_jirl;
    op.use_less     = inst_blt | inst_bge | inst_bltu | inst_bgeu;
    op.need_less    = inst_blt | inst_bltu;
    op.use_zero     = inst_beq | inst_bne;
    op.need_zero    = inst_beq;
    op.src1_is_pc   = src1_is_pc;
    op.src2_is_imm  = src2_is_imm;
    op.src2_is_4    = src2_is_4;
    op.gr_we        = gr_we;
    // unknown words leave nothing behind but pc and operands
    op.dest         = recognized ? dest : '0;
    op.imm          = recognized ? imm : '0;
    op.rj_addr      = rj_addr;
    op.rkd_addr     = rkd_addr;
    op.rj_value     = rj_value;
    op.rkd_value    = rkd_value;
    op.pc           = pc;
  end

  assign hazard.dest       = dest;
  assign hazard.gr_we      = gr_we;
  assign hazard.use_rj     = inst_jirl | ~src1_is_pc;
  assign hazard.use_rkd    = ~(src2_is_imm | src2_is_4);
  assign hazard.may_jump   = may_jump;
  assign hazard.mem_access = is_load | is_store;
  assign hazard.rj_addr    = rj_addr;
  assign hazard.rkd_addr   = rkd_addr;

endmodule

// ==== design/issue_control.sv ====
module issue_control import decode_pkg::*; (
  input  logic         slot0_valid,
  input  logic         slot1_valid,
  input  hazard_info_t hazard0,
  input  hazard_info_t hazard1,
  input  logic         ready,
  output logic [1:0]   issue_valid,
  output logic [1:0]   pop
);

  logic serialize;
  logic raw_rj;
  logic raw_rkd;
  logic slot0_writes;

  // jumps in slot 0 and any memory access keep the pair apart
  assign serialize = hazard0.may_jump | hazard0.mem_access | hazard1.mem_access;

  // writes to r0 never create a dependency
  assign slot0_writes = hazard0.gr_we & (|hazard0.dest);
  assign raw_rj  = hazard1.use_rj  & (hazard0.dest == hazard1.rj_addr);
  assign raw_rkd = hazard1.use_rkd & (hazard0.dest == hazard1.rkd_addr);

  assign issue_valid[0] = slot0_valid;
  assign issue_valid[1] = slot1_valid & ~serialize & ~(slot0_writes & (raw_rj | raw_rkd));

  assign pop = issue_valid & {2{ready}};

endmodule

// ==== design/issue_reg.sv ====
module issue_reg import decode_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        flush,
  input  logic        ready,
  input  logic [1:0]  issue_valid,
  input  decoded_op_t op0,
  input  decoded_op_t op1,
  output issue_slot_t issue0,
  output issue_slot_t issue1
);

  // flush takes priority over back-pressure
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      issue0 <= '0;
      issue1 <= '0;
    end else if (ready) begin
      issue0.valid <= issue_valid[0];
      issue0.op    <= op0;
      issue1.valid <= issue_valid[1];
      issue1.op    <= op1;
    end
  end

endmodule

// ==== verif/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// flag order follows decoded_op_t with load first and gr_we last
localparam logic [12:0] F_LOAD  = 13'h1000;
localparam logic [12:0] F_STORE = 13'h0800;
localparam logic [12:0] F_UNS   = 13'h0400;
localparam logic [12:0] F_JUMP  = 13'h0200;
localparam logic [12:0] F_RJV   = 13'h0100;
localparam logic [12:0] F_ULESS = 13'h0080;
localparam logic [12:0] F_NLESS = 13'h0040;
localparam logic [12:0] F_UZERO = 13'h0020;
localparam logic [12:0] F_NZERO = 13'h0010;
localparam logic [12:0] F_S1PC  = 13'h0008;
localparam logic [12:0] F_S2IMM = 13'h0004;
localparam logic [12:0] F_S24   = 13'h0002;
localparam logic [12:0] F_WE    = 13'h0001;

typedef struct {
  string                       name;
  fetch_slot_t                 s0;
  fetch_slot_t                 s1;
  logic                        ready;
  logic                        flush;
  logic [1:0]                  pop;
  logic [3:0][`REG_ADDR_W-1:0] addr;
  issue_slot_t                 e0;
  issue_slot_t                 e1;
} vec_t;

vec_t table_q[$];

function automatic logic [31:0] enc_3r(logic [3:0] op4, logic [1:0] op2, logic [4:0] op5,
                                       logic [4:0] rk, logic [4:0] rj, logic [4:0] rd);
  return {`OP6_ARITH, op4, op2, op5, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_2ri12(logic [5:0] op6, logic [3:0] op4,
                                          logic [11:0] imm12, logic [4:0] rj, logic [4:0] rd);
  return {op6, op4, imm12, rj, rd};
endfunction

function automatic logic [31:0] enc_1ri20(logic [5:0] op6, logic [19:0] imm20, logic [4:0] rd);
  return {op6, 1'b0, imm20, rd};
endfunction

function automatic logic [31:0] enc_2ri16(logic [5:0] op6, logic [15:0] imm16,
                                          logic [4:0] rj, logic [4:0] rd);
  return {op6, imm16, rj, rd};
endfunction

// low half of the offset sits above the high half
function automatic logic [31:0] enc_i26(logic [5:0] op6, logic [25:0] offs);
  return {op6, offs[15:0], offs[25:16]};
endfunction

function automatic decoded_op_t exp_op(logic [31:0] pc, int alu, logic [3:0] mask,
                                       logic [12:0] flags, logic [4:0] dest,
                                       logic [31:0] imm, logic [4:0] rj, logic [4:0] rkd);
  decoded_op_t o;
  o = '0;
  if (alu >= 0) begin
    o.alu_op[alu] = 1'b1;
  end
  o.mem_mask = mask;
  {o.load, o.store, o.is_unsigned, o.may_jump, o.use_rj_value, o.use_less, o.need_less,
   o.use_zero, o.need_zero, o.src1_is_pc, o.src2_is_imm, o.src2_is_4, o.gr_we} = flags;
  o.dest      = dest;
  o.imm       = imm;
  o.rj_addr   = rj;
  o.rkd_addr  = rkd;
  o.rj_value  = rf_word(rj);
  o.rkd_value = rf_word(rkd);
  o.pc        = pc;
  return o;
endfunction

// 3r forms carry no immediate, so the 12-bit field comes out zero-extended
function automatic decoded_op_t add_op(logic [31:0] w, logic [4:0] rd, logic [4:0] rj,
                                       logic [4:0] rk);
  return exp_op($urandom, `ALU_ADD, 4'h0, F_WE, rd, {20'h0, w[21:10]}, rj, rk);
endfunction

task automatic add_row(string name, fetch_slot_t s0, fetch_slot_t s1, decoded_op_t o0,
                       decoded_op_t o1, logic [1:0] issue, logic ready, logic flush);
  vec_t v;
  v.name  = name;
  v.s0    = s0;
  v.s1    = s1;
  v.ready = ready;
  v.flush = flush;
  v.pop   = ready ? issue : 2'b00;
  // read ports in slot order, rj before rkd
  v.addr  = {o1.rkd_addr, o1.rj_addr, o0.rkd_addr, o0.rj_addr};
  if (flush) begin
    v.e0 = '0;
    v.e1 = '0;
  end else if (ready) begin
    v.e0.valid = issue[0];
    v.e0.op    = o0;
    v.e1.valid = issue[1];
    v.e1.op    = o1;
  end else begin
    v.e0 = (table_q.size() > 0) ? table_q[$].e0 : '0;
    v.e1 = (table_q.size() > 0) ? table_q[$].e1 : '0;
  end
  table_q.push_back(v);
endtask

task automatic decode_row(string name, logic [31:0] w, int alu, logic [3:0] mask,
                          logic [12:0] flags, logic [4:0] dest, logic [31:0] imm,
                          logic rkd_is_rd);
  fetch_slot_t s0;
  decoded_op_t o0;
  logic [4:0]  rkd;
  rkd = rkd_is_rd ? w[4:0] : w[14:10];
  o0 = exp_op($urandom, alu, mask, flags, dest, imm, w[9:5], rkd);
  s0.valid = 1'b1;
  s0.pc    = o0.pc;
  s0.instr = w;
  add_row(name, s0, '0, o0, '0, 2'b01, 1'b1, 1'b0);
endtask

task automatic row_3r(string name, logic [4:0] op5, int alu);
  logic [31:0] w;
  w = enc_3r(`OP4_3R, `OP2_3R, op5, 5'd6, 5'd5, 5'd4);
  decode_row(name, w, alu, 4'h0, F_WE, 5'd4, {20'h0, w[21:10]}, 1'b0);
endtask

task automatic row_shift(string name, logic [4:0] op5, int alu);
  decode_row(name, enc_3r(`OP4_SHIFTI, `OP2_SHIFTI, op5, 5'd7, 5'd5, 5'd4), alu, 4'h0,
             F_S2IMM | F_WE, 5'd4, 32'd7, 1'b0);
endtask

task automatic row_imm(string name, logic [3:0] op4, int alu, logic [11:0] imm12,
                       logic [31:0] exp_imm);
  decode_row(name, enc_2ri12(`OP6_ARITH, op4, imm12, 5'd5, 5'd4), alu, 4'h0,
             F_S2IMM | F_WE, 5'd4, exp_imm, 1'b0);
endtask

task automatic row_mem(string name, logic [3:0] op4, logic [3:0] mask, logic [12:0] flags);
  decode_row(name, enc_2ri12(`OP6_MEM, op4, 12'hffc, 5'd5, 5'd4), `ALU_ADD, mask,
             flags | F_S2IMM, 5'd4, 32'hffff_fffc, |(flags & F_STORE));
endtask

task automatic row_br(string name, logic [5:0] op6, int alu, logic [12:0] flags);
  decode_row(name, enc_2ri16(op6, 16'h8004, 5'd5, 5'd4), alu, 4'h0, F_JUMP | flags, 5'd4,
             32'hffff_8004, 1'b1);
endtask

task automatic pair_row(string name, logic [31:0] w0, decoded_op_t o0, logic [31:0] w1,
                        decoded_op_t o1, logic [1:0] issue, logic ready, logic flush);
  fetch_slot_t s0;
  fetch_slot_t s1;
  s0.valid = 1'b1;
  s0.pc    = o0.pc;
  s0.instr = w0;
  s1.valid = 1'b1;
  s1.pc    = o1.pc;
  s1.instr = w1;
  add_row(name, s0, s1, o0, o1, issue, ready, flush);
endtask

task automatic pair_add(string name, logic [4:0] rd0, rj0, rk0, rd1, rj1, rk1,
                        logic [1:0] issue, logic ready, logic flush);
  logic [31:0] w0;
  logic [31:0] w1;
  w0 = enc_3r(`OP4_3R, `OP2_3R, `OP5_ADD, rk0, rj0, rd0);
  w1 = enc_3r(`OP4_3R, `OP2_3R, `OP5_ADD, rk1, rj1, rd1);
  pair_row(name, w0, add_op(w0, rd0, rj0, rk0), w1, add_op(w1, rd1, rj1, rk1),
           issue, ready, flush);
endtask

task automatic build_table();
  logic [31:0] w;
  logic [31:0] wa;
  decoded_op_t oa;
  row_3r("add.w", `OP5_ADD, `ALU_ADD);
  row_3r("sub.w", `OP5_SUB, `ALU_SUB);
  row_3r("slt", `OP5_SLT, `ALU_SLT);
  row_3r("sltu", `OP5_SLTU, `ALU_SLTU);
  row_3r("and", `OP5_AND, `ALU_AND);
  row_3r("or", `OP5_OR, `ALU_OR);
  row_3r("xor", `OP5_XOR, `ALU_XOR);
  row_3r("nor", `OP5_NOR, `ALU_NOR);
  row_3r("sll.w", `OP5_SLL, `ALU_SLL);
  row_3r("srl.w", `OP5_SRL, `ALU_SRL);
  row_3r("sra.w", `OP5_SRA, `ALU_SRA);
  row_shift("slli.w", `OP5_SLLI, `ALU_SLL);
  row_shift("srli.w", `OP5_SRLI, `ALU_SRL);
  row_shift("srai.w", `OP5_SRAI, `ALU_SRA);
  row_imm("addi.w", `OP4_ADDI, `ALU_ADD, 12'hf80, 32'hffff_ff80);
  row_imm("slti", `OP4_SLTI, `ALU_SLT, 12'h801, 32'hffff_f801);
  row_imm("sltui", `OP4_SLTUI, `ALU_SLTU, 12'h7ff, 32'h0000_07ff);
  // logic immediates are zero-extended
  row_imm("andi", `OP4_ANDI, `ALU_AND, 12'hf0f, 32'h0000_0f0f);
  row_imm("ori", `OP4_ORI, `ALU_OR, 12'h8a5, 32'h0000_08a5);
  row_imm("xori", `OP4_XORI, `ALU_XOR, 12'hfff, 32'h0000_0fff);
  row_mem("ld.b", `OP4_LD_B, `MASK_B, F_LOAD | F_WE);
  row_mem("ld.h", `OP4_LD_H, `MASK_H, F_LOAD | F_WE);
  row_mem("ld.w", `OP4_LD_W, `MASK_W, F_LOAD | F_WE);
  row_mem("ld.bu", `OP4_LD_BU, `MASK_B, F_LOAD | F_UNS | F_WE);
  row_mem("ld.hu", `OP4_LD_HU, `MASK_H, F_LOAD | F_UNS | F_WE);
  row_mem("st.b", `OP4_ST_B, `MASK_B, F_STORE);
  row_mem("st.h", `OP4_ST_H, `MASK_H, F_STORE);
  row_mem("st.w", `OP4_ST_W, `MASK_W, F_STORE);
  w = enc_1ri20(`OP6_LU12I, 20'h81234, 5'd4);
  decode_row("lu12i.w", w, `ALU_LUI, 4'h0, F_S2IMM | F_WE, 5'd4, 32'h8123_4000, 1'b0);
  w = enc_1ri20(`OP6_PCADDU, 20'h00abc, 5'd4);
  decode_row("pcaddu12i", w, `ALU_ADD, 4'h0, F_S1PC | F_S2IMM | F_WE, 5'd4, 32'h00ab_c000,
             1'b0);
  row_br("beq", `OP6_BEQ, `ALU_SUB, F_UZERO | F_NZERO);
  row_br("bne", `OP6_BNE, `ALU_SUB, F_UZERO);
  row_br("blt", `OP6_BLT, `ALU_SLT, F_ULESS | F_NLESS);
  row_br("bge", `OP6_BGE, `ALU_SLT, F_ULESS);
  row_br("bltu", `OP6_BLTU, `ALU_SLTU, F_ULESS | F_NLESS);
  row_br("bgeu", `OP6_BGEU, `ALU_SLTU, F_ULESS);
  w = enc_2ri16(`OP6_JIRL, 16'h0010, 5'd5, 5'd4);
  decode_row("jirl", w, `ALU_ADD, 4'h0, F_JUMP | F_RJV | F_S1PC | F_S24 | F_WE, 5'd4,
             32'h0000_0010, 1'b0);
  w = enc_i26(`OP6_B, 26'h3ff_fff0);
  decode_row("b", w, -1, 4'h0, F_JUMP, w[4:0], 32'hffff_fff0, 1'b0);
  // bl links into r1
  w = enc_i26(`OP6_BL, 26'h000_0100);
  decode_row("bl", w, `ALU_ADD, 4'h0, F_JUMP | F_S1PC | F_S24 | F_WE, 5'd1, 32'h0000_0100,
             1'b0);
  decode_row("unknown", 32'hffff_ffff, -1, 4'h0, 13'h0, 5'd0, 32'h0, 1'b0);

  pair_add("alu_pair", 4, 5, 6, 7, 8, 9, 2'b11, 1'b1, 1'b0);
  pair_add("raw_rj", 4, 5, 6, 7, 4, 9, 2'b01, 1'b1, 1'b0);
  pair_add("raw_rkd", 4, 5, 6, 7, 8, 4, 2'b01, 1'b1, 1'b0);
  pair_add("raw_r0", 0, 5, 6, 7, 0, 0, 2'b11, 1'b1, 1'b0);
  wa = enc_3r(`OP4_3R, `OP2_3R, `OP5_ADD, 5'd6, 5'd5, 5'd4);
  oa = add_op(wa, 5'd4, 5'd5, 5'd6);
  // rk field of addi matches r4 but is not read
  pair_row("imm_no_rkd", wa, oa, enc_2ri12(`OP6_ARITH, `OP4_ADDI, 12'h004, 5'd8, 5'd7),
           exp_op($urandom, `ALU_ADD, 4'h0, F_S2IMM | F_WE, 5'd7, 32'h4, 5'd8, 5'd4),
           2'b11, 1'b1, 1'b0);
  pair_row("branch_slot0", enc_2ri16(`OP6_BEQ, 16'h0008, 5'd5, 5'd4),
           exp_op($urandom, `ALU_SUB, 4'h0, F_JUMP | F_UZERO | F_NZERO, 5'd4, 32'h8, 5'd5,
                  5'd4), wa, oa, 2'b01, 1'b1, 1'b0);
  pair_row("jump_slot0", enc_i26(`OP6_B, 26'h40),
           exp_op($urandom, -1, 4'h0, F_JUMP, 5'd0, 32'h40, 5'd0, 5'd0), wa, oa, 2'b01,
           1'b1, 1'b0);
  pair_row("load_slot0", enc_2ri12(`OP6_MEM, `OP4_LD_W, 12'h020, 5'd5, 5'd10),
           exp_op($urandom, `ALU_ADD, `MASK_W, F_LOAD | F_S2IMM | F_WE, 5'd10, 32'h20, 5'd5,
                  5'd0), wa, oa, 2'b01, 1'b1, 1'b0);
  pair_row("store_slot1", wa, oa, enc_2ri12(`OP6_MEM, `OP4_ST_W, 12'h004, 5'd8, 5'd9),
           exp_op($urandom, `ALU_ADD, `MASK_W, F_STORE | F_S2IMM, 5'd9, 32'h4, 5'd8, 5'd9),
           2'b01, 1'b1, 1'b0);
  pair_add("stall", 11, 12, 13, 14, 15, 16, 2'b11, 1'b0, 1'b0);
  pair_add("resume", 11, 12, 13, 14, 15, 16, 2'b11, 1'b1, 1'b0);
  pair_add("flush_stalled", 4, 5, 6, 7, 8, 9, 2'b11, 1'b0, 1'b1);
  pair_add("after_flush", 17, 18, 19, 20, 21, 22, 2'b11, 1'b1, 1'b0);
  pair_add("flush_ready", 4, 5, 6, 7, 8, 9, 2'b11, 1'b1, 1'b1);
  pair_add("last_pair", 23, 24, 25, 26, 27, 28, 2'b11, 1'b1, 1'b0);
endtask

`endif

// ==== verif/tb_decode_stage.sv ====
`include "decode_defs.svh"

module tb_decode_stage import decode_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;

  logic                          clk;
  logic                          reset;
  logic                          ready;
  logic                          flush;
  fetch_slot_t                   slot0;
  fetch_slot_t                   slot1;
  logic [3:0][`DATA_W-1:0]       rf_data;
  logic [1:0]                    pop;
  logic [3:0][`REG_ADDR_W-1:0]   rf_addr;
  issue_slot_t                   issue0;
  issue_slot_t                   issue1;
  logic                          table_built = 1'b0;

  // register file model repeats the address in every byte
  function automatic logic [`DATA_W-1:0] rf_word(logic [`REG_ADDR_W-1:0] addr);
    return {4{3'b000, addr}};
  endfunction

  `include "tb_vectors.svh"

  decode_stage uut (
    .clk     (clk),
    .reset   (reset),
    .ready   (ready),
    .flush   (flush),
    .slot0   (slot0),
    .slot1   (slot1),
    .rf_data (rf_data),
    .pop     (pop),
    .rf_addr (rf_addr),
    .issue0  (issue0),
    .issue1  (issue1)
  );

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rf_data[i] = rf_word(rf_addr[i]);
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_pop(string name, logic [1:0] exp, logic [1:0] act);
    if (act !== exp) begin
      $display("ERR %s pop expected %b actual %b", name, exp, act);
      $display("Verification failed");
      $fatal(1, "pop mismatch");
    end
  endtask

  task automatic check_addr(string name, logic [3:0][`REG_ADDR_W-1:0] exp,
                            logic [3:0][`REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("ERR %s rf_addr expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "register address mismatch");
    end
  endtask

  task automatic check_slot(string name, issue_slot_t exp, issue_slot_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Verification failed");
      $fatal(1, "issue slot mismatch");
    end
  endtask

  initial begin
    void'($urandom(25));
    reset = 1'b1;
    ready = 1'b0;
    flush = 1'b0;
    slot0 = '0;
    slot1 = '0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    ready = 1'b1;
    check_slot("reset.issue0", '0, issue0);
    check_slot("reset.issue1", '0, issue1);
    for (int i = 0; i < table_q.size(); i++) begin
      @(negedge clk);
      slot0 = table_q[i].s0;
      slot1 = table_q[i].s1;
      ready = table_q[i].ready;
      flush = table_q[i].flush;
      #1;
      check_pop(table_q[i].name, table_q[i].pop, pop);
      check_addr(table_q[i].name, table_q[i].addr, rf_addr);
      @(posedge clk);
      #1;
      check_slot({table_q[i].name, ".issue0"}, table_q[i].e0, issue0);
      check_slot({table_q[i].name, ".issue1"}, table_q[i].e1, issue1);
    end
    $display("Verification passed");
    $finish;
  end

  // table rows plus reset plus some slack
  initial begin
    wait (table_built);
    #((table_q.size() + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the table did not finish within the expected number of cycles");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

endmodule
